// ==== include/rob_params.svh ====
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// ====================
// Reorder buffer sizing
// ====================

// Number of entries in the ring, which has to be a power of two so the
// index pointers wrap on their own
`define ROB_ENTRIES 16

// Bits needed to address one entry, log2 of the entry count
`define ROB_IDX_BITS 4

// Width of the late-arriving payload word
`define ROB_DATA_BITS 32

// Width of the meta-data captured when an entry is allocated
`define ROB_META_BITS 8

// Allocation stops while fewer than this many slots would remain free.
// A value of 1 keeps one slot in reserve so the ring never fills completely
`define ROB_MIN_FREE_SLOTS 1

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the reorder buffer testbench with Verilator and runs it.
# The run passes only if the pass line shows up in the simulation output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module rob_tb -o rob_sim \
    && ./obj_dir/rob_sim | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sim.f ====
+incdir+include
source/rob_index_pkg.sv
source/rob_payload_pkg.sv
source/rob_allocator.sv
source/rob_storage.sv
source/rob_retire.sv
source/rob_top.sv
verif/rob_clock_gen.sv
verif/rob_tb.sv

// ==== source/rob_allocator.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rob_params.svh"

// Hands out entry indices in ring order and tracks how many entries are
// currently allocated, so the requester knows when to stop
module rob_allocator
(
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire logic                  alloc,
    input  wire logic                  release_en,
    output rob_index_pkg::idx_t        newest,
    output logic                       not_full
);

    // Number of entries that are allocated and not yet released
    rob_index_pkg::count_t occupancy;

    // ====================
    // Index pointer
    // ====================

    // The pointer names the slot that the next alloc will take.
    // Its width matches the ring size, so it wraps to 0 by itself
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            newest <= '0;
        end
        else if (alloc)
        begin
            newest <= newest + rob_index_pkg::idx_t'(1);
        end
    end

    // ====================
    // Occupancy and full level
    // ====================

    // An alloc and a release in the same cycle cancel out
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            occupancy <= '0;
        end
        else if (alloc && !release_en)
        begin
            occupancy <= occupancy + rob_index_pkg::count_t'(1);
        end
        else if (!alloc && release_en)
        begin
            occupancy <= occupancy - rob_index_pkg::count_t'(1);
        end
    end

    // Room remains as long as the reserved free slots are still left over
    // after counting every allocated entry
    assign not_full = ((occupancy + rob_index_pkg::count_t'(`ROB_MIN_FREE_SLOTS)) <
                       rob_index_pkg::count_t'(`ROB_ENTRIES));

endmodule

`default_nettype wire

// ==== source/rob_index_pkg.sv ====
`default_nettype none

`include "rob_params.svh"

// Types that describe positions in the ring and how many of them are in use
package rob_index_pkg;

    // Index of one entry in the ring
    typedef logic [`ROB_IDX_BITS-1:0] idx_t;

    // Occupancy count with one extra bit, wide enough for both an empty
    // ring and a completely full one
    typedef logic [`ROB_IDX_BITS:0] count_t;

endpackage

`default_nettype wire

// ==== source/rob_payload_pkg.sv ====
`default_nettype none

`include "rob_params.svh"

// Types that describe what a single entry holds
package rob_payload_pkg;

    // Payload word, written some time after allocation
    typedef logic [`ROB_DATA_BITS-1:0] data_t;

    // Meta-data word, written in the allocation cycle
    typedef logic [`ROB_META_BITS-1:0] meta_t;

endpackage

`default_nettype wire

// ==== source/rob_retire.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rob_params.svh"

// Retire stage of the reorder buffer.  It follows the oldest entry around
// the ring, reports when that entry has its payload, and returns the
// payload and meta-data through a two-stage register pipeline
module rob_retire
(
    input  wire logic                   clk,
    input  wire logic                   reset_n,

    // Consumer dequeue strobe
    input  wire logic                   deq_en,

    // Head entry as seen by the storage
    input  wire logic                   head_valid,
    input  wire rob_payload_pkg::data_t head_data,
    input  wire rob_payload_pkg::meta_t head_meta,

    // Control back to allocator and storage
    output rob_index_pkg::idx_t         oldest,
    output logic                        release_en,

    // Ordered output
    output logic                        not_empty,
    output rob_payload_pkg::data_t      first,
    output rob_payload_pkg::meta_t      first_meta
);

    // First read stage
    logic                   s1_valid;
    rob_payload_pkg::data_t s1_data;
    rob_payload_pkg::meta_t s1_meta;

    // ====================
    // Head tracking
    // ====================

    // The head can leave only once its payload is present
    assign not_empty = head_valid;

    // A dequeue counts only while the head is ready
    assign release_en = deq_en && head_valid;

    // Each retired entry moves the head one slot along, wrapping at the end
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            oldest <= '0;
        end
        else if (release_en)
        begin
            oldest <= oldest + rob_index_pkg::idx_t'(1);
        end
    end

    // ====================
    // Read pipeline
    // ====================

    // Stage one samples the head at the dequeue edge.  Its flag marks that
    // stage two must pick the sample up on the next edge
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            s1_valid <= 1'b0;
        end
        else
        begin
            s1_valid <= release_en;
        end
    end

    always_ff @(posedge clk)
    begin
        if (release_en)
        begin
            s1_data <= head_data;
            s1_meta <= head_meta;
        end
    end

    // Stage two drives the outputs, which hold until the next dequeue
    // works its way through
    always_ff @(posedge clk)
    begin
        if (s1_valid)
        begin
            first <= s1_data;
            first_meta <= s1_meta;
        end
    end

endmodule

`default_nettype wire

// ==== source/rob_storage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rob_params.svh"

// Entry storage for the reorder buffer.  Meta-data is written when an entry
// is allocated, the payload arrives later through a registered write port,
// and a valid flag per entry tells the retire stage the payload is present
module rob_storage
(
    input  wire logic                   clk,
    input  wire logic                   reset_n,

    // Allocation side
    input  wire logic                   alloc,
    input  wire rob_index_pkg::idx_t    newest,
    input  wire rob_payload_pkg::meta_t alloc_meta,

    // Payload write port that accepts every write
    input  wire logic                   enq_data_en,
    input  wire rob_index_pkg::idx_t    enq_data_idx,
    input  wire rob_payload_pkg::data_t enq_data,

    // Retire side
    input  wire rob_index_pkg::idx_t    oldest,
    input  wire logic                   release_en,
    output logic                        head_valid,
    output rob_payload_pkg::data_t      head_data,
    output rob_payload_pkg::meta_t      head_meta
);

    // Entry arrays
    rob_payload_pkg::data_t data_mem [`ROB_ENTRIES];
    rob_payload_pkg::meta_t meta_mem [`ROB_ENTRIES];

    // One flag per entry, set once its payload has landed
    logic [`ROB_ENTRIES-1:0] valid_flags;

    // Payload write after its register stage
    logic                   wr_en_q;
    rob_index_pkg::idx_t    wr_idx_q;
    rob_payload_pkg::data_t wr_data_q;

    // ====================
    // Meta-data capture
    // ====================

    // The meta-data goes into the slot the allocator names in the same cycle
    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            meta_mem[newest] <= alloc_meta;
        end
    end

    // ====================
    // Payload write path
    // ====================

    // Incoming writes are registered once to keep the array write off the
    // input pins
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_en_q <= 1'b0;
        end
        else
        begin
            wr_en_q <= enq_data_en;
        end
        wr_idx_q <= enq_data_idx;
        wr_data_q <= enq_data;
    end

    // The registered write lands in the data array one edge later
    always_ff @(posedge clk)
    begin
        if (wr_en_q)
        begin
            data_mem[wr_idx_q] <= wr_data_q;
        end
    end

    // A flag is set when its payload lands and cleared when the entry
    // retires.  The two never hit the same entry in one cycle, since the
    // oldest entry is already written and the written one is still pending
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            valid_flags <= '0;
        end
        else
        begin
            if (release_en)
            begin
                valid_flags[oldest] <= 1'b0;
            end
            if (wr_en_q)
            begin
                valid_flags[wr_idx_q] <= 1'b1;
            end
        end
    end

    // Everything the retire stage needs is read at the oldest index
    assign head_valid = valid_flags[oldest];
    assign head_data  = data_mem[oldest];
    assign head_meta  = meta_mem[oldest];

endmodule

`default_nettype wire

// ==== source/rob_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rob_params.svh"

// Reorder buffer top level.  Entries are allocated in order, filled in any
// order, and handed back in allocation order two cycles after each dequeue
module rob_top
(
    input  wire logic                   clk,
    input  wire logic                   reset_n,

    // Allocation
    input  wire logic                   alloc,
    input  wire rob_payload_pkg::meta_t alloc_meta,
    output rob_index_pkg::idx_t         alloc_idx,
    output logic                        not_full,

    // Payload write
    input  wire logic                   enq_data_en,
    input  wire rob_index_pkg::idx_t    enq_data_idx,
    input  wire rob_payload_pkg::data_t enq_data,

    // Ordered output
    input  wire logic                   deq_en,
    output logic                        not_empty,
    output rob_payload_pkg::data_t      first,
    output rob_payload_pkg::meta_t      first_meta
);

    // Retire stage outputs used by the other blocks
    rob_index_pkg::idx_t    oldest;
    logic                   release_en;

    // Head entry seen by the retire stage
    logic                   head_valid;
    rob_payload_pkg::data_t head_data;
    rob_payload_pkg::meta_t head_meta;

    // The newest pointer is the index returned to the requester
    rob_allocator allocator_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .alloc      (alloc),
        .release_en (release_en),
        .newest     (alloc_idx),
        .not_full   (not_full)
    );

    rob_storage storage_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .alloc        (alloc),
        .newest       (alloc_idx),
        .alloc_meta   (alloc_meta),
        .enq_data_en  (enq_data_en),
        .enq_data_idx (enq_data_idx),
        .enq_data     (enq_data),
        .oldest       (oldest),
        .release_en   (release_en),
        .head_valid   (head_valid),
        .head_data    (head_data),
        .head_meta    (head_meta)
    );

    rob_retire retire_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .deq_en     (deq_en),
        .head_valid (head_valid),
        .head_data  (head_data),
        .head_meta  (head_meta),
        .oldest     (oldest),
        .release_en (release_en),
        .not_empty  (not_empty),
        .first      (first),
        .first_meta (first_meta)
    );

endmodule

`default_nettype wire

// ==== verif/rob_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

// Free-running testbench clock, plus a reset that is held low for the
// first sixteen rising edges
module rob_clock_gen
(
    output logic clk,
    output logic reset_n
);

    // Period is 100 ns, so each half lasts 50 ns
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    // Reset is released on a falling edge so it is stable at the next rising one
    initial
    begin
        reset_n = 1'b0;
        repeat (16)
        begin
            @(posedge clk);
        end
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/rob_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rob_params.svh"

// Testbench for the reorder buffer.  A reference model follows the timing
// rules of the buffer, and concurrent assertions compare it with the DUT
module rob_tb;

    logic clk;
    logic reset_n;

    // DUT inputs
    logic                   alloc;
    rob_payload_pkg::meta_t alloc_meta;
    logic                   enq_data_en;
    rob_index_pkg::idx_t    enq_data_idx;
    rob_payload_pkg::data_t enq_data;
    logic                   deq_en;

    // DUT outputs
    rob_index_pkg::idx_t    alloc_idx;
    logic                   not_full;
    logic                   not_empty;
    rob_payload_pkg::data_t first;
    rob_payload_pkg::meta_t first_meta;

    // Model state, advanced on the rising edge
    rob_index_pkg::idx_t     exp_alloc_idx;
    rob_index_pkg::idx_t     exp_oldest;
    rob_index_pkg::count_t   exp_occ;
    logic [`ROB_ENTRIES-1:0] exp_valid;
    logic                    wr_pend_en;
    rob_index_pkg::idx_t     wr_pend_idx;
    logic                    rd1_valid;
    rob_payload_pkg::data_t  rd1_data;
    rob_payload_pkg::meta_t  rd1_meta;
    logic                    exp_first_known;
    rob_payload_pkg::data_t  exp_first;
    rob_payload_pkg::meta_t  exp_first_meta;
    logic                    exp_release;
    logic                    exp_not_full;
    logic                    exp_not_empty;

    // Allocation order, and what each index holds or will be written with
    rob_index_pkg::idx_t    q_idx[$];
    rob_index_pkg::idx_t    pending[$];
    rob_payload_pkg::data_t planned_data [`ROB_ENTRIES];
    rob_payload_pkg::meta_t planned_meta [`ROB_ENTRIES];

    // Expected output of the dequeue driven in the current cycle
    rob_payload_pkg::data_t deq_data_exp;
    rob_payload_pkg::meta_t deq_meta_exp;

    integer seed = 94207;
    int     mismatch_count = 0;
    int     timeout_count = 0;
    int     i;
    logic   ok;
    rob_index_pkg::idx_t hold_idx;

    rob_clock_gen clock_gen_i (
        .clk     (clk),
        .reset_n (reset_n)
    );

    rob_top dut_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .alloc        (alloc),
        .alloc_meta   (alloc_meta),
        .alloc_idx    (alloc_idx),
        .not_full     (not_full),
        .enq_data_en  (enq_data_en),
        .enq_data_idx (enq_data_idx),
        .enq_data     (enq_data),
        .deq_en       (deq_en),
        .not_empty    (not_empty),
        .first        (first),
        .first_meta   (first_meta)
    );

    // ====================
    // Reference model
    // ====================

    // The head leaves only once its payload is in, and the full level keeps
    // the reserved slots free
    assign exp_not_empty = exp_valid[exp_oldest];
    assign exp_release = deq_en && exp_not_empty;
    assign exp_not_full = (exp_occ + rob_index_pkg::count_t'(`ROB_MIN_FREE_SLOTS)) <
                          rob_index_pkg::count_t'(`ROB_ENTRIES);

    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            exp_alloc_idx <= '0;
            exp_oldest <= '0;
            exp_occ <= '0;
            exp_valid <= '0;
            wr_pend_en <= 1'b0;
            rd1_valid <= 1'b0;
            exp_first_known <= 1'b0;
        end
        else
        begin
            if (alloc)
            begin
                exp_alloc_idx <= exp_alloc_idx + rob_index_pkg::idx_t'(1);
            end
            exp_occ <= exp_occ + rob_index_pkg::count_t'(alloc) -
                       rob_index_pkg::count_t'(exp_release);
            // A payload waits one edge, then marks its entry ready
            wr_pend_en <= enq_data_en;
            wr_pend_idx <= enq_data_idx;
            if (exp_release)
            begin
                exp_valid[exp_oldest] <= 1'b0;
                exp_oldest <= exp_oldest + rob_index_pkg::idx_t'(1);
            end
            if (wr_pend_en)
            begin
                exp_valid[wr_pend_idx] <= 1'b1;
            end
            // Dequeued values reach the outputs two edges later
            rd1_valid <= exp_release;
            if (exp_release)
            begin
                rd1_data <= deq_data_exp;
                rd1_meta <= deq_meta_exp;
            end
            if (rd1_valid)
            begin
                exp_first <= rd1_data;
                exp_first_meta <= rd1_meta;
                exp_first_known <= 1'b1;
            end
        end
    end

    // ====================
    // Checks
    // ====================

    reset_state_check: assert property (@(posedge clk)
        $rose(reset_n) |-> (!not_empty && not_full && alloc_idx == '0))
    else
    begin
        mismatch_count++;
        $display("mismatch reset state: not_empty=%h not_full=%h alloc_idx=%h, expected 0 1 0",
                 $sampled(not_empty), $sampled(not_full), $sampled(alloc_idx));
    end

    alloc_idx_check: assert property (@(posedge clk) disable iff (!reset_n)
        alloc_idx == exp_alloc_idx)
    else
    begin
        mismatch_count++;
        $display("mismatch alloc_idx: got %h expected %h",
                 $sampled(alloc_idx), $sampled(exp_alloc_idx));
    end

    not_full_check: assert property (@(posedge clk) disable iff (!reset_n)
        not_full == exp_not_full)
    else
    begin
        mismatch_count++;
        $display("mismatch not_full: got %h expected %h",
                 $sampled(not_full), $sampled(exp_not_full));
    end

    not_empty_check: assert property (@(posedge clk) disable iff (!reset_n)
        not_empty == exp_not_empty)
    else
    begin
        mismatch_count++;
        $display("mismatch not_empty: got %h expected %h",
                 $sampled(not_empty), $sampled(exp_not_empty));
    end

    first_check: assert property (@(posedge clk) disable iff (!reset_n)
        exp_first_known |-> first == exp_first)
    else
    begin
        mismatch_count++;
        $display("mismatch first: got %h expected %h", $sampled(first), $sampled(exp_first));
    end

    first_meta_check: assert property (@(posedge clk) disable iff (!reset_n)
        exp_first_known |-> first_meta == exp_first_meta)
    else
    begin
        mismatch_count++;
        $display("mismatch first_meta: got %h expected %h",
                 $sampled(first_meta), $sampled(exp_first_meta));
    end

    // ====================
    // Stimulus helpers
    // ====================

    function automatic int random_below(input int size);
        return int'($unsigned($random(seed)) % size);
    endfunction

    function automatic logic coin_flip();
        return 1'($random(seed));
    endfunction

    task automatic clear_strobes();
        alloc = 1'b0;
        enq_data_en = 1'b0;
        deq_en = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            clear_strobes();
        end
    endtask

    // Takes the slot the model says is next and plans its payload
    task automatic issue_alloc();
        alloc = 1'b1;
        alloc_meta = rob_payload_pkg::meta_t'($random(seed));
        planned_meta[exp_alloc_idx] = alloc_meta;
        planned_data[exp_alloc_idx] = rob_payload_pkg::data_t'($random(seed));
        q_idx.push_back(exp_alloc_idx);
        pending.push_back(exp_alloc_idx);
    endtask

    task automatic issue_write(input int pos);
        rob_index_pkg::idx_t idx;
        idx = pending[pos];
        pending.delete(pos);
        enq_data_en = 1'b1;
        enq_data_idx = idx;
        enq_data = planned_data[idx];
    endtask

    task automatic issue_dequeue();
        rob_index_pkg::idx_t idx;
        idx = q_idx.pop_front();
        deq_en = 1'b1;
        deq_data_exp = planned_data[idx];
        deq_meta_exp = planned_meta[idx];
    endtask

    // Holds the strobes low until not_empty or not_full is seen high
    task automatic wait_ready(input logic for_deq, output logic ready);
        int n;
        n = 0;
        while (((for_deq ? not_empty : not_full) !== 1'b1) && n < 64)
        begin
            @(negedge clk);
            clear_strobes();
            n++;
        end
        ready = ((for_deq ? not_empty : not_full) === 1'b1);
        if (!ready)
        begin
            timeout_count++;
            $display("timeout: %s stayed low for 64 cycles", for_deq ? "not_empty" : "not_full");
        end
    endtask

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        alloc = 1'b0;
        alloc_meta = '0;
        enq_data_en = 1'b0;
        enq_data_idx = '0;
        enq_data = '0;
        deq_en = 1'b0;
        deq_data_exp = '0;
        deq_meta_exp = '0;

        i = 0;
        while (reset_n !== 1'b1 && i < 40)
        begin
            @(posedge clk);
            i++;
        end
        if (reset_n !== 1'b1)
        begin
            timeout_count++;
            $display("timeout: reset was never released");
        end

        // Fill to the threshold, then leave the oldest entry unwritten
        for (i = 0; i < `ROB_ENTRIES - 1; i++)
        begin
            @(negedge clk);
            clear_strobes();
            wait_ready(1'b0, ok);
            if (ok)
            begin
                issue_alloc();
            end
        end
        idle(1);
        hold_idx = pending.pop_front();
        while (pending.size() > 0)
        begin
            @(negedge clk);
            clear_strobes();
            issue_write(random_below(pending.size()));
        end
        idle(4);

        // Writing the oldest releases the whole backlog
        @(negedge clk);
        clear_strobes();
        pending.push_back(hold_idx);
        issue_write(0);
        @(negedge clk);
        clear_strobes();
        wait_ready(1'b1, ok);
        if (ok)
        begin
            issue_dequeue();
        end
        idle(2);
        // Back-to-back dequeues of what is left
        while (q_idx.size() > 0)
        begin
            @(negedge clk);
            clear_strobes();
            wait_ready(1'b1, ok);
            if (!ok)
            begin
                break;
            end
            issue_dequeue();
        end
        idle(4);

        // Random traffic, several trips around the ring
        for (i = 0; i < 200; i++)
        begin
            @(negedge clk);
            clear_strobes();
            if (pending.size() > 0 && coin_flip())
            begin
                issue_write(random_below(pending.size()));
            end
            if (not_full && coin_flip())
            begin
                issue_alloc();
            end
            if (not_empty && q_idx.size() > 0 && coin_flip())
            begin
                issue_dequeue();
            end
        end

        // Drain whatever is still allocated
        i = 0;
        while (q_idx.size() > 0 && i < 200)
        begin
            @(negedge clk);
            clear_strobes();
            if (pending.size() > 0)
            begin
                issue_write(random_below(pending.size()));
            end
            if (not_empty)
            begin
                issue_dequeue();
            end
            i++;
        end
        if (q_idx.size() > 0)
        begin
            timeout_count++;
            $display("timeout: buffer did not drain, %0d entries left", q_idx.size());
        end
        idle(4);

        $display("error counts: mismatches %0d, timeouts %0d", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
